// ==== lab_pkg.sv ====
package lab_pkg;

    localparam int DEBOUNCE_DEPTH   = 8;  // stable samples before a debounced bit follows
    localparam int DEB_CNT_W        = $clog2(DEBOUNCE_DEPTH + 1);
    localparam int STROBE_WIDTH_DEF = 23; // about 6 strobes per second at 50 MHz
    localparam int LED_W            = 10;
    localparam int NUM_DIGITS       = 6;

    typedef logic [LED_W-1:0] led_t;      // shift register and red leds
    typedef logic [15:0]      count16_t;  // strobe count and encoder position
    typedef logic [7:0]       count8_t;   // detector hit counts
    typedef logic [31:0]      disp_t;     // word offered to the seven segment digits
    typedef logic [6:0]       seg_t;      // active low segments g..a

    // both detectors look for 1,0,1 with overlap
    typedef enum logic [1:0] {
        MOORE_IDLE,
        MOORE_GOT1,
        MOORE_GOT10,
        MOORE_FOUND
    } moore_state_t;

    typedef enum logic [1:0] {
        MEALY_IDLE,
        MEALY_GOT1,
        MEALY_GOT10
    } mealy_state_t;

endpackage

// ==== sync_debounce.sv ====
`timescale 1ns/1ps

module sync_debounce #(
    parameter int W = 1
) (
    input  logic         i_clk,
    input  logic         i_arst_n,
    input  logic [W-1:0] i_in,
    output logic [W-1:0] o_out
);
    import lab_pkg::*;

    logic [W-1:0]         sync1_q;
    logic [W-1:0]         sync2_q;
    logic [DEB_CNT_W-1:0] stable_cnt_q [W]; // cycles the synced bit has differed from o_out

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
            o_out   <= '0;
            for (int i = 0; i < W; i++) begin
                stable_cnt_q[i] <= '0;
            end
        end else begin
            sync1_q <= i_in;    // first metastability stage
            sync2_q <= sync1_q;
            for (int i = 0; i < W; i++) begin
                if (sync2_q[i] == o_out[i]) begin
                    stable_cnt_q[i] <= '0;  // any bounce back restarts the count
                end else if (stable_cnt_q[i] == DEB_CNT_W'(DEBOUNCE_DEPTH)) begin
                    o_out[i]        <= sync2_q[i];
                    stable_cnt_q[i] <= '0;
                end else begin
                    stable_cnt_q[i] <= stable_cnt_q[i] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== lab_ctrl.sv ====
`timescale 1ns/1ps

module lab_ctrl #(
    parameter int STROBE_WIDTH = lab_pkg::STROBE_WIDTH_DEF
) (
    input  logic          i_clk,
    input  logic          i_arst_n,
    input  logic          i_key,
    output logic          o_strobe,
    output lab_pkg::led_t o_leds,
    output logic          o_moore_hit,
    output logic          o_mealy_hit
);
    import lab_pkg::*;

    logic [STROBE_WIDTH-1:0] timer_q;
    logic                    strobe_q;
    led_t                    shift_q;
    moore_state_t            moore_state_q;
    moore_state_t            moore_next;
    mealy_state_t            mealy_state_q;
    mealy_state_t            mealy_next;

    // free running timer, the strobe follows its wrap by one cycle
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            timer_q  <= '0;
            strobe_q <= 1'b0;
        end else begin
            timer_q  <= timer_q + 1'b1;
            strobe_q <= &timer_q;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            shift_q <= '0;
        end else if (strobe_q) begin
            shift_q <= {shift_q[LED_W-2:0], i_key}; // newest bit enters at bit 0
        end
    end

    // i_key is the bit being shifted in on this strobe
    always_comb begin
        moore_next = moore_state_q;
        case (moore_state_q)
            MOORE_IDLE:  moore_next = i_key ? MOORE_GOT1  : MOORE_IDLE;
            MOORE_GOT1:  moore_next = i_key ? MOORE_GOT1  : MOORE_GOT10;
            MOORE_GOT10: moore_next = i_key ? MOORE_FOUND : MOORE_IDLE;
            MOORE_FOUND: moore_next = i_key ? MOORE_GOT1  : MOORE_GOT10; // last 1 starts over
            default:     moore_next = MOORE_IDLE;
        endcase
    end

    always_comb begin
        mealy_next = mealy_state_q;
        case (mealy_state_q)
            MEALY_IDLE:  mealy_next = i_key ? MEALY_GOT1 : MEALY_IDLE;
            MEALY_GOT1:  mealy_next = i_key ? MEALY_GOT1 : MEALY_GOT10;
            MEALY_GOT10: mealy_next = i_key ? MEALY_GOT1 : MEALY_IDLE;
            default:     mealy_next = MEALY_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            moore_state_q <= MOORE_IDLE;
            mealy_state_q <= MEALY_IDLE;
        end else if (strobe_q) begin
            moore_state_q <= moore_next;
            mealy_state_q <= mealy_next;
        end
    end

    assign o_strobe    = strobe_q;
    assign o_leds      = shift_q;
    // moore sees the hit one strobe late since FOUND is a state of its own
    assign o_moore_hit = strobe_q && (moore_state_q == MOORE_FOUND);
    assign o_mealy_hit = strobe_q && (mealy_state_q == MEALY_GOT10) && i_key;

endmodule

// ==== event_counters.sv ====
`timescale 1ns/1ps

module event_counters (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_strobe,
    input  logic              i_moore_hit,
    input  logic              i_mealy_hit,
    output lab_pkg::count16_t o_strobe_cnt,
    output lab_pkg::count8_t  o_moore_cnt,
    output lab_pkg::count8_t  o_mealy_cnt
);
    import lab_pkg::*;

    count16_t strobe_cnt_q;
    count8_t  moore_cnt_q;
    count8_t  mealy_cnt_q;

    // all three counters simply wrap on overflow
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            strobe_cnt_q <= '0;
            moore_cnt_q  <= '0;
            mealy_cnt_q  <= '0;
        end else begin
            if (i_strobe) begin
                strobe_cnt_q <= strobe_cnt_q + 1'b1;
            end
            if (i_moore_hit) begin
                moore_cnt_q <= moore_cnt_q + 1'b1;  // hits already carry the strobe
            end
            if (i_mealy_hit) begin
                mealy_cnt_q <= mealy_cnt_q + 1'b1;
            end
        end
    end

    assign o_strobe_cnt = strobe_cnt_q;
    assign o_moore_cnt  = moore_cnt_q;
    assign o_mealy_cnt  = mealy_cnt_q;

endmodule

// ==== rotary_encoder.sv ====
`timescale 1ns/1ps

module rotary_encoder (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_a,
    input  logic              i_b,
    output lab_pkg::count16_t o_value
);
    import lab_pkg::*;

    logic     a_prev_q;
    logic     a_rise;
    count16_t value_q;  // two's complement position

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            a_prev_q <= 1'b0;
        end else begin
            a_prev_q <= i_a;
        end
    end

    assign a_rise = i_a && !a_prev_q;

    // B low on the rising edge of A means clockwise
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            value_q <= '0;
        end else if (a_rise) begin
            if (i_b) begin
                value_q <= value_q - 1'b1;
            end else begin
                value_q <= value_q + 1'b1;
            end
        end
    end

    assign o_value = value_q;

endmodule

// ==== hex_display.sv ====
`timescale 1ns/1ps

module hex_display (
    input  logic                           i_disp_sel,
    input  lab_pkg::disp_t                 i_counts,
    input  lab_pkg::count16_t              i_enc_value,
    input  logic                           i_enc_btn,
    input  logic                           i_enc_swt,
    input  logic [lab_pkg::NUM_DIGITS-1:0] i_dp_n,
    output logic [7:0]                     o_hex0,
    output logic [7:0]                     o_hex1,
    output logic [7:0]                     o_hex2,
    output logic [7:0]                     o_hex3,
    output logic [7:0]                     o_hex4,
    output logic [7:0]                     o_hex5
);
    import lab_pkg::*;

    disp_t disp_word;
    seg_t  segs [NUM_DIGITS];

    // segment order is g..a, a zero lights the segment
    function automatic seg_t seg_decode(input logic [3:0] nibble);
        case (nibble)
            4'h0:    seg_decode = 7'b100_0000;
            4'h1:    seg_decode = 7'b111_1001;
            4'h2:    seg_decode = 7'b010_0100;
            4'h3:    seg_decode = 7'b011_0000;
            4'h4:    seg_decode = 7'b001_1001;
            4'h5:    seg_decode = 7'b001_0010;
            4'h6:    seg_decode = 7'b000_0010;
            4'h7:    seg_decode = 7'b111_1000;
            4'h8:    seg_decode = 7'b000_0000;
            4'h9:    seg_decode = 7'b001_0000;
            4'ha:    seg_decode = 7'b000_1000;
            4'hb:    seg_decode = 7'b000_0011;  // lower case b
            4'hc:    seg_decode = 7'b100_0110;
            4'hd:    seg_decode = 7'b010_0001;  // lower case d
            4'he:    seg_decode = 7'b000_0110;
            default: seg_decode = 7'b000_1110;
        endcase
    endfunction

    always_comb begin
        if (i_disp_sel) begin
            disp_word = {{8{i_enc_btn}}, {8{i_enc_swt}}, i_enc_value};
        end else begin
            disp_word = i_counts;   // strobes, moore hits, mealy hits
        end
    end

    always_comb begin
        for (int d = 0; d < NUM_DIGITS; d++) begin
            segs[d] = seg_decode(disp_word[4*d +: 4]);
        end
    end

    // decimal point sits in bit 7 of each digit
    assign o_hex0 = {i_dp_n[0], segs[0]};
    assign o_hex1 = {i_dp_n[1], segs[1]};
    assign o_hex2 = {i_dp_n[2], segs[2]};
    assign o_hex3 = {i_dp_n[3], segs[3]};
    assign o_hex4 = {i_dp_n[4], segs[4]};
    assign o_hex5 = {i_dp_n[5], segs[5]};

endmodule

// ==== board_lab_top.sv ====
`timescale 1ns/1ps

module board_lab_top #(
    parameter int STROBE_WIDTH = lab_pkg::STROBE_WIDTH_DEF
) (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_key_n,
    input  logic [lab_pkg::LED_W-1:0] i_sw,
    input  logic                      i_enc_a,
    input  logic                      i_enc_b,
    input  logic                      i_enc_btn,
    input  logic                      i_enc_swt,
    output logic [lab_pkg::LED_W-1:0] o_ledr,
    output logic [7:0]                o_hex0,
    output logic [7:0]                o_hex1,
    output logic [7:0]                o_hex2,
    output logic [7:0]                o_hex3,
    output logic [7:0]                o_hex4,
    output logic [7:0]                o_hex5
);
    import lab_pkg::*;

    logic     key_db;
    led_t     sw_db;
    logic     enc_a_db;
    logic     enc_b_db;
    logic     enc_btn_db;
    logic     enc_swt_db;
    logic     strobe;
    logic     moore_hit;
    logic     mealy_hit;
    count16_t strobe_cnt;
    count8_t  moore_cnt;
    count8_t  mealy_cnt;
    count16_t enc_value;

    sync_debounce #(.W(LED_W + 1)) debounce_keysw_i (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_in     ({~i_key_n, i_sw}),   // key pressed reads as 1
        .o_out    ({key_db, sw_db})
    );

    sync_debounce #(.W(4)) debounce_enc_i (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_in     ({i_enc_a, i_enc_b, i_enc_btn, i_enc_swt}),
        .o_out    ({enc_a_db, enc_b_db, enc_btn_db, enc_swt_db})
    );

    lab_ctrl #(.STROBE_WIDTH(STROBE_WIDTH)) ctrl_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_key       (key_db),
        .o_strobe    (strobe),
        .o_leds      (o_ledr),
        .o_moore_hit (moore_hit),
        .o_mealy_hit (mealy_hit)
    );

    event_counters counters_i (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_strobe     (strobe),
        .i_moore_hit  (moore_hit),
        .i_mealy_hit  (mealy_hit),
        .o_strobe_cnt (strobe_cnt),
        .o_moore_cnt  (moore_cnt),
        .o_mealy_cnt  (mealy_cnt)
    );

    rotary_encoder encoder_i (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_a      (enc_a_db),
        .i_b      (enc_b_db),
        .o_value  (enc_value)
    );

    // only sw[0] and sw[5:0] reach the display, the upper switches are spare
    hex_display display_i (
        .i_disp_sel  (sw_db[0]),
        .i_counts    ({strobe_cnt, moore_cnt, mealy_cnt}),
        .i_enc_value (enc_value),
        .i_enc_btn   (enc_btn_db),
        .i_enc_swt   (enc_swt_db),
        .i_dp_n      (~sw_db[NUM_DIGITS-1:0]),
        .o_hex0      (o_hex0),
        .o_hex1      (o_hex1),
        .o_hex2      (o_hex2),
        .o_hex3      (o_hex3),
        .o_hex4      (o_hex4),
        .o_hex5      (o_hex5)
    );

endmodule

// ==== tb_board_lab.sv ====
`timescale 1ns/1ps

module tb_board_lab;
    import lab_pkg::*;

    localparam int   STROBE_W       = 6;
    localparam int   STROBE_PERIOD  = 1 << STROBE_W;
    localparam int   RESET_CYCLES   = 8;
    localparam int   NUM_RANDOM     = 20;
    localparam int   TIMEOUT_CYCLES = 5000;  // 46 periods of 64 cycles is about 2950, plus margin
    localparam led_t SW_INIT        = 10'b00_0010_1010;

    logic       i_clk;
    logic       i_arst_n;
    logic       i_key_n;
    led_t       i_sw;
    logic       i_enc_a;
    logic       i_enc_b;
    logic       i_enc_btn;
    logic       i_enc_swt;
    led_t       o_ledr;
    logic [7:0] o_hex0;
    logic [7:0] o_hex1;
    logic [7:0] o_hex2;
    logic [7:0] o_hex3;
    logic [7:0] o_hex4;
    logic [7:0] o_hex5;

    logic drv_key;  // levels put on the pins at the start of the next period
    led_t drv_sw;
    logic drv_a;
    logic drv_b;
    logic drv_btn;
    logic drv_swt;

    led_t     exp_leds;     // reference model state
    count16_t exp_strobes;
    count8_t  exp_moore;
    count8_t  exp_mealy;
    count16_t exp_pos;
    logic     model_a;

    logic        check_en;
    logic [47:0] exp_digits;
    logic [47:0] got_digits;
    int          checks;
    int          errors;
    int          test_errors;
    int          cycle_cnt;
    integer      seed;
    logic [31:0] rand_val;

    board_lab_top #(.STROBE_WIDTH(STROBE_W)) dut_i (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_key_n   (i_key_n),
        .i_sw      (i_sw),
        .i_enc_a   (i_enc_a),
        .i_enc_b   (i_enc_b),
        .i_enc_btn (i_enc_btn),
        .i_enc_swt (i_enc_swt),
        .o_ledr    (o_ledr),
        .o_hex0    (o_hex0),
        .o_hex1    (o_hex1),
        .o_hex2    (o_hex2),
        .o_hex3    (o_hex3),
        .o_hex4    (o_hex4),
        .o_hex5    (o_hex5)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // lit segments in gfedcba order, the board wants them inverted
    function automatic seg_t segments_for(input logic [3:0] nibble);
        logic [6:0] lit;
        case (nibble)
            4'h0:    lit = 7'h3f;
            4'h1:    lit = 7'h06;
            4'h2:    lit = 7'h5b;
            4'h3:    lit = 7'h4f;
            4'h4:    lit = 7'h66;
            4'h5:    lit = 7'h6d;
            4'h6:    lit = 7'h7d;
            4'h7:    lit = 7'h07;
            4'h8:    lit = 7'h7f;
            4'h9:    lit = 7'h6f;
            4'ha:    lit = 7'h77;
            4'hb:    lit = 7'h7c;
            4'hc:    lit = 7'h39;
            4'hd:    lit = 7'h5e;
            4'he:    lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    // returns {hex5, ..., hex0} for the given switch, count and encoder levels
    function automatic logic [47:0] expected_digits(
        input led_t     sw,
        input count16_t strobes,
        input count8_t  moore,
        input count8_t  mealy,
        input count16_t pos,
        input logic     btn,
        input logic     swt
    );
        disp_t       word;
        logic [47:0] digits;
        digits = '0;
        if (sw[0]) begin
            word = {{8{btn}}, {8{swt}}, pos};
        end else begin
            word = {strobes, moore, mealy};
        end
        for (int n = 0; n < NUM_DIGITS; n++) begin
            digits[8*n +: 8] = {~sw[n], segments_for(word[4*n +: 4])};
        end
        return digits;
    endfunction

    // a hit is the window 1,0,1 ending at the new bit (mealy) or at the previous one (moore)
    task automatic apply_strobe(input logic key);
        if ({exp_leds[1:0], key} == 3'b101) begin
            exp_mealy = exp_mealy + 8'd1;
        end
        if (exp_leds[2:0] == 3'b101) begin
            exp_moore = exp_moore + 8'd1;
        end
        exp_leds    = {exp_leds[LED_W-2:0], key};
        exp_strobes = exp_strobes + 16'd1;
    endtask

    task automatic apply_encoder(input logic a, input logic b);
        if (a && !model_a) begin
            if (b) begin
                exp_pos = exp_pos - 16'd1;
            end else begin
                exp_pos = exp_pos + 16'd1;
            end
        end
        model_a = a;
    endtask

    // starts at a mid period edge and ends at the next one, with one compare just before
    task automatic run_period();
        i_key_n   <= ~drv_key;
        i_sw      <= drv_sw;
        i_enc_a   <= drv_a;
        i_enc_b   <= drv_b;
        i_enc_btn <= drv_btn;
        i_enc_swt <= drv_swt;
        repeat (STROBE_PERIOD - 1) @(posedge i_clk);
        apply_strobe(drv_key);
        apply_encoder(drv_a, drv_b);
        check_en <= 1'b1;
        @(posedge i_clk);
        check_en <= 1'b0;
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic check_decimal_points();
        logic [5:0] got_dp;
        got_dp = {got_digits[47], got_digits[39], got_digits[31],
                  got_digits[23], got_digits[15], got_digits[7]};
        checks++;
        if (got_dp !== ~drv_sw[5:0]) begin
            errors++;
            $display("error: decimal points expected 0x%h got 0x%h", ~drv_sw[5:0], got_dp);
        end
    endtask

    // two digits of the last sampled display against the segments of one byte
    task automatic check_byte_shown(input string name, input int digit, input count8_t value);
        seg_t got_hi;
        seg_t got_lo;
        got_lo = got_digits[8*digit +: 7];
        got_hi = got_digits[8*digit+8 +: 7];
        checks++;
        if ({got_hi, got_lo} !== {segments_for(value[7:4]), segments_for(value[3:0])}) begin
            errors++;
            $display("error: %s expected 0x%h, digits show segments 0x%h 0x%h",
                     name, value, got_hi, got_lo);
        end
    endtask

    always @(negedge i_clk) begin
        if (check_en) begin
            exp_digits = expected_digits(drv_sw, exp_strobes, exp_moore, exp_mealy,
                                         exp_pos, drv_btn, drv_swt);
            got_digits = {o_hex5, o_hex4, o_hex3, o_hex2, o_hex1, o_hex0};
            checks++;
            if (o_ledr !== exp_leds) begin
                errors++;
                $display("error: o_ledr expected 0x%h got 0x%h", exp_leds, o_ledr);
            end
            for (int d = 0; d < NUM_DIGITS; d++) begin
                if (got_digits[8*d +: 8] !== exp_digits[8*d +: 8]) begin
                    errors++;
                    $display("error: o_hex%0d expected 0x%h got 0x%h", d,
                             exp_digits[8*d +: 8], got_digits[8*d +: 8]);
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        seed        = 5;
        cycle_cnt   = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        check_en    = 1'b0;
        i_arst_n    = 1'b0;
        i_key_n     = 1'b1;
        i_sw        = SW_INIT;
        i_enc_a     = 1'b0;
        i_enc_b     = 1'b0;
        i_enc_btn   = 1'b0;
        i_enc_swt   = 1'b0;
        drv_key     = 1'b0;
        drv_sw      = SW_INIT;
        drv_a       = 1'b0;
        drv_b       = 1'b0;
        drv_btn     = 1'b0;
        drv_swt     = 1'b0;
        exp_leds    = '0;
        exp_strobes = '0;
        exp_moore   = '0;
        exp_mealy   = '0;
        exp_pos     = '0;
        model_a     = 1'b0;

        repeat (RESET_CYCLES) @(posedge i_clk);
        i_arst_n <= 1'b1;

        repeat (STROBE_PERIOD / 2 - 1) @(posedge i_clk);  // compare lands well before the first strobe
        check_en <= 1'b1;
        @(posedge i_clk);
        check_en <= 1'b0;
        report_test("1 reset state");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_val = $random(seed);
            drv_key  = rand_val[0];
            run_period();
        end
        report_test("2 shift register");

        drv_key = 1'b0;
        repeat (3) run_period();  // trailing zeros let the moore count catch up
        report_test("3 event counts");

        drv_key = 1'b1;
        run_period();
        drv_key = 1'b0;
        run_period();
        drv_key = 1'b1;
        run_period();
        check_byte_shown("mealy count", 0, exp_moore + 8'd1);
        check_byte_shown("moore count", 2, exp_moore);
        drv_key = 1'b0;
        run_period();
        check_byte_shown("mealy count", 0, exp_moore);
        check_byte_shown("moore count", 2, exp_moore);
        report_test("4 mealy leads moore");

        drv_sw[0] = 1'b1;
        drv_btn   = 1'b1;
        run_period();
        repeat (5) begin
            drv_a = 1'b1;
            run_period();
            drv_a = 1'b0;
            run_period();
        end
        drv_b = 1'b1;  // B settles high before A rises again
        run_period();
        repeat (2) begin
            drv_a = 1'b1;
            run_period();
            drv_a = 1'b0;
            run_period();
        end
        drv_b   = 1'b0;
        drv_btn = 1'b0;
        drv_swt = 1'b1;
        run_period();
        check_byte_shown("encoder position high byte", 2, 8'h00);
        check_byte_shown("encoder position low byte", 0, 8'h03);
        report_test("5 encoder");

        drv_sw = 10'b10_1010_0101;
        run_period();
        check_decimal_points();
        drv_sw = 10'b01_0101_1010;
        run_period();
        check_decimal_points();
        report_test("6 decimal points");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== files.f ====
lab_pkg.sv
sync_debounce.sv
lab_ctrl.sv
event_counters.sv
rotary_encoder.sv
hex_display.sv
board_lab_top.sv
tb_board_lab.sv

// ==== Makefile ====
# Verilator flow for the board lab subsystem

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_board_lab
RTL_TOP   ?= board_lab_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
